/* sim.f */
+incdir+tests
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_regfile.sv
rtl/rv_decoder.sv
rtl/rv_forward.sv
rtl/rv_core.sv
tests/rv_core_assert.sv
tests/tb_rv_core.sv

/* Makefile */
# Verilator build and regression run for the rv_core testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the regression, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert --top-module tb_rv_core -f sim.f --Mdir obj_dir
	./obj_dir/Vtb_rv_core | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/tb_programs.svh */
// program table: instruction words, expected store counts and expected stores per program
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam int n_programs     = 6;    // table depth
localparam int prog_len       = 12;   // words per program, rest of imem is nop
localparam int max_stores     = 3;
localparam int timeout_cycles = 200;  // per program, until halt

typedef struct packed {
    word_t addr;
    word_t data;
} store_t;

localparam instr_t prog_tab [n_programs][prog_len] = '{
    // 0: dependent alu chain, x1=5 x2=3 x3=8 x4=3 x5=0xb x6=0x58 x7=1
    '{32'h00500093, 32'h00300113, 32'h002081b3, 32'h40118233, 32'h003242b3, 32'h00229333,
      32'h006223b3, 32'h08602023, 32'h08702223, 32'h08502423, 32'h00000073, 32'h00000013},
    // 1: lw then addi +5, lw then sw of the loaded word
    '{32'h04002083, 32'h00508113, 32'h08202823, 32'h04402183, 32'h08302a23, 32'h00000073,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013},
    // 2: bne not taken, beq taken over an ecall and a store, bne target stores x0
    '{32'h00700093, 32'h00700113, 32'h02209263, 32'h0a102023, 32'h00208663, 32'h00000073,
      32'h0a202423, 32'h00900193, 32'h0a302623, 32'h00000073, 32'h00000013, 32'h0a002823},
    // 3: jal x1,+12 and jalr x2,4(x5) with x5=0x20, skipped words store x0
    '{32'h00c000ef, 32'h0c002023, 32'h0c002223, 32'h0c102423, 32'h02000293, 32'h00428167,
      32'h0c002623, 32'h0c002823, 32'h0c002a23, 32'h0c202c23, 32'h00000073, 32'h00000013},
    // 4: addi x0 and add x0 results must never show up in sw x0
    '{32'h05500013, 32'h0e002023, 32'h03300093, 32'h00108033, 32'h0e002223, 32'h0e002423,
      32'h00000073, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013},
    // 5: one store, ecall, then two stores that must never issue
    '{32'h01100093, 32'h0e102823, 32'h00000073, 32'h0e102a23, 32'h0e102c23, 32'h00000013,
      32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013, 32'h00000013}
};

localparam int exp_count_tab [n_programs] = '{3, 2, 2, 2, 3, 1};

// {address, data}, loaded words follow the dmem fill 5a5a0000 ^ address
localparam store_t exp_tab [n_programs][max_stores] = '{
    '{{32'h80, 32'h58}, {32'h84, 32'h1}, {32'h88, 32'hb}},
    '{{32'h90, 32'h5a5a_0045}, {32'h94, 32'h5a5a_0044}, {32'h0, 32'h0}},
    '{{32'ha0, 32'h7}, {32'hac, 32'h9}, {32'h0, 32'h0}},
    '{{32'hc8, 32'h4}, {32'hd8, 32'h18}, {32'h0, 32'h0}},  // link values pc+4
    '{{32'he0, 32'h0}, {32'he4, 32'h0}, {32'he8, 32'h0}},
    '{{32'hf0, 32'h11}, {32'h0, 32'h0}, {32'h0, 32'h0}}
};

`endif

/* tests/tb_rv_core.sv */
// testbench for rv_core: clock, reset, memory models, program table loop, compare tasks, summary
`timescale 1ns/1ps

module tb_rv_core
    import rv_pkg::*;
();

    `include "tb_programs.svh"

    logic   clk;
    logic   rst_n;
    word_t  imem_addr;
    instr_t imem_data;
    word_t  dmem_addr;
    word_t  dmem_wdata;
    logic   dmem_we;
    word_t  dmem_rdata;
    logic   halt;

    instr_t imem [64];   // 256 bytes each, word indexed
    word_t  dmem [64];
    store_t seen [$];    // stores observed in the current run
    int     err_value;
    int     err_count;
    int     err_timeout;

    rv_core u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .halt       (halt)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period

    // ========================================================================
    // memory models, async read and write at the rising edge
    // ========================================================================
    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we) dmem[dmem_addr[7:2]] <= dmem_wdata;
    end

    function automatic word_t fill_word(input word_t addr);
        return 32'h5a5a_0000 ^ addr;  // every address bit shows up in the data
    endfunction

    task automatic load_program(input int p);
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < prog_len) ? prog_tab[p][i] : nop_instr;
            dmem[i] <= fill_word(word_t'(i * 4));
        end
    endtask

    task automatic reset_core(input int p);
        @(posedge clk);
        #1 rst_n = 1'b0;
        load_program(p);
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    // ========================================================================
    // run and compare
    // ========================================================================
    task automatic record_store();
        if (dmem_we) seen.push_back(store_t'({dmem_addr, dmem_wdata}));
    endtask

    task automatic run_program(input int p);
        int cycles;
        cycles = 0;
        seen.delete();
        do begin
            @(negedge clk);  // outputs settled half a cycle after the edge
            record_store();
            cycles++;
        end while (!halt && cycles < timeout_cycles);
        if (!halt) begin
            $display("program %0d did not raise halt within %0d cycles", p, timeout_cycles);
            err_timeout++;
        end
        repeat (4) begin   // drain, nothing may store behind the marker
            @(negedge clk);
            record_store();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            err_value++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_stores(input int p);
        check_count($sformatf("store count program %0d", p), seen.size(), exp_count_tab[p]);
        for (int i = 0; i < exp_count_tab[p] && i < seen.size(); i++) begin
            check_word($sformatf("dmem_addr program %0d store %0d", p, i),
                       seen[i].addr, exp_tab[p][i].addr);
            check_word($sformatf("dmem_wdata program %0d store %0d", p, i),
                       seen[i].data, exp_tab[p][i].data);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        err_value   = 0;
        err_count   = 0;
        err_timeout = 0;
        load_program(0);
        for (int p = 0; p < n_programs; p++) begin
            $display("program %0d", p);
            reset_core(p);
            run_program(p);
            compare_stores(p);
        end
        $display("errors: %0d value, %0d count, %0d timeout", err_value, err_count, err_timeout);
        if (err_value + err_count + err_timeout == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* tests/rv_core_assert.sv */
// concurrent checks on rv_core data port and halt, bound into the core
`timescale 1ns/1ps

module rv_core_assert (
    input logic clk,
    input logic rst_n,
    input logic dmem_we,
    input logic halt
);

    // no store while in reset or in the first cycle out of it
    a_we_reset: assert property (@(posedge clk) !rst_n |-> !dmem_we)
        else $error("dmem_we high during reset");
    // first clocked cycle after release, memory stage loaded from the reset id/ex
    a_we_release: assert property (@(posedge clk) $rose(rst_n) |=> !dmem_we)
        else $error("dmem_we high in the cycle after reset");

    // halt is sticky until the next reset
    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
        else $error("halt dropped without reset");

    a_no_store_halted: assert property (@(posedge clk) disable iff (!rst_n) halt |-> !dmem_we)
        else $error("store issued while halted");

endmodule

bind rv_core rv_core_assert u_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .dmem_we (dmem_we),
    .halt    (halt)
);

/* rtl/rv_core.sv */
// rv32i five-stage core: pc, stage registers, branch resolution, flush, forwarding and writeback
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    output word_t  imem_addr,
    input  instr_t imem_data,
    output word_t  dmem_addr,
    output word_t  dmem_wdata,
    output logic   dmem_we,
    input  word_t  dmem_rdata,
    output logic   halt
);

    word_t     pc, pc_next;
    logic      stop_q;        // halt seen in decode, fetch frozen
    logic      halt_q;        // sticky halt once marker left writeback
    logic      halt_stop;
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    instr_t    id_instr;      // decode instr after flush
    reg_addr_t id_rs1, id_rs2, id_rd;
    word_t     id_imm;
    ctrl_t     id_ctrl;
    word_t     rf_rs1_data, rf_rs2_data;
    word_t     id_rs1_data, id_rs2_data;
    logic      byp_a, byp_b;
    fwd_sel_e  fwd_a, fwd_b;
    word_t     ex_a, ex_rs2;  // forwarded operands
    word_t     ex_b;
    word_t     alu_result;
    logic      alu_zero, alu_less;
    logic      branch_taken;
    logic      redirect;      // taken branch or jump in execute
    word_t     target;
    word_t     wb_data;

    // operand pick in execute, reg means the id/ex copy
    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            fwd_mem_alu:  return ex_mem.alu;
            fwd_mem_load: return dmem_rdata;  // async read, same cycle
            fwd_mem_pc4:  return ex_mem.pc4;
            fwd_wb:       return wb_data;
            default:      return reg_val;
        endcase
    endfunction

    // ========================================================================
    // fetch
    // ========================================================================
    assign imem_addr = pc;
    assign halt_stop = id_ctrl.halt | stop_q;  // flushed halt never decodes as halt

    always_comb begin
        if (redirect)       pc_next = target;
        else if (halt_stop) pc_next = pc;      // hold, fetch feeds nops
        else                pc_next = pc + word_t'(4);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= '0;
            stop_q <= 1'b0;
            halt_q <= 1'b0;
            if_id  <= '{instr: nop_instr, pc: '0};
        end else begin
            pc          <= pc_next;
            stop_q      <= halt_stop;
            halt_q      <= halt_q | mem_wb.halt;
            if_id.pc    <= pc;
            if_id.instr <= (redirect || halt_stop) ? nop_instr : imem_data;
        end
    end

    assign halt = halt_q | mem_wb.halt;  // high from the cycle the marker sits in wb

    // ========================================================================
    // decode
    // ========================================================================
    assign id_instr = redirect ? nop_instr : if_id.instr;  // younger instr killed

    rv_decoder u_decoder (
        .instr (id_instr),
        .rs1   (id_rs1),
        .rs2   (id_rs2),
        .rd    (id_rd),
        .imm   (id_imm),
        .ctrl  (id_ctrl)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (id_rs1),
        .rs2_addr (id_rs2),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .we       (mem_wb.rf_we),
        .rd_addr  (mem_wb.rd),
        .rd_data  (wb_data)
    );

    rv_forward u_forward (
        .id_rs1     (id_rs1),
        .id_rs2     (id_rs2),
        .ex_rs1     (id_ex.rs1),
        .ex_rs2     (id_ex.rs2),
        .mem_rd     (ex_mem.rd),
        .wb_rd      (mem_wb.rd),
        .mem_rf_we  (ex_mem.rf_we),
        .wb_rf_we   (mem_wb.rf_we),
        .mem_wb_sel (ex_mem.wb_sel),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .byp_a      (byp_a),
        .byp_b      (byp_b)
    );

    assign id_rs1_data = byp_a ? wb_data : rf_rs1_data;
    assign id_rs2_data = byp_b ? wb_data : rf_rs2_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;  // control cleared, behaves as a bubble
        end else begin
            id_ex <= '{rs1_data: id_rs1_data, rs2_data: id_rs2_data, imm: id_imm,
                       pc: if_id.pc, rs1: id_rs1, rs2: id_rs2, rd: id_rd, ctrl: id_ctrl};
        end
    end

    // ========================================================================
    // execute
    // ========================================================================
    always_comb begin
        ex_a   = fwd_mux(fwd_a, id_ex.rs1_data);
        ex_rs2 = fwd_mux(fwd_b, id_ex.rs2_data);
    end

    assign ex_b = id_ex.ctrl.use_imm ? id_ex.imm : ex_rs2;

    rv_alu u_alu (
        .op     (id_ex.ctrl.alu_op),
        .a      (ex_a),
        .b      (ex_b),
        .result (alu_result),
        .zero   (alu_zero),
        .less   (alu_less)
    );

    always_comb begin
        case (id_ex.ctrl.branch)
            br_eq:   branch_taken = alu_zero;
            br_ne:   branch_taken = !alu_zero;
            br_lt:   branch_taken = alu_less;
            br_ge:   branch_taken = !alu_less;
            default: branch_taken = 1'b0;
        endcase
    end

    assign redirect = branch_taken | id_ex.ctrl.jump;
    // jalr takes rs1+imm with bit 0 cleared, branches and jal are pc relative
    assign target = id_ex.ctrl.jalr ? {alu_result[xlen-1:1], 1'b0} : id_ex.pc + id_ex.imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.alu        <= alu_result;
            ex_mem.store_data <= ex_rs2;
            ex_mem.pc4        <= id_ex.pc + word_t'(4);
            ex_mem.rd         <= id_ex.rd;
            ex_mem.mem_we     <= id_ex.ctrl.mem_we;
            ex_mem.wb_sel     <= id_ex.ctrl.wb_sel;
            ex_mem.rf_we      <= id_ex.ctrl.rf_we;
            ex_mem.halt       <= id_ex.ctrl.halt;
        end
    end

    // ========================================================================
    // memory and writeback
    // ========================================================================
    assign dmem_addr  = ex_mem.alu;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.mem_we;  // one cycle per store

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{alu: ex_mem.alu, load_data: dmem_rdata, pc4: ex_mem.pc4, rd: ex_mem.rd,
                        wb_sel: ex_mem.wb_sel, rf_we: ex_mem.rf_we, halt: ex_mem.halt};
        end
    end

    always_comb begin
        case (mem_wb.wb_sel)
            wb_mem:  wb_data = mem_wb.load_data;
            wb_pc4:  wb_data = mem_wb.pc4;       // link value
            default: wb_data = mem_wb.alu;
        endcase
    end

endmodule

/* rtl/rv_forward.sv */
// hazard detection: execute operand forwarding selects and decode writeback bypass
`timescale 1ns/1ps

module rv_forward
    import rv_pkg::*;
(
    input  reg_addr_t id_rs1,
    input  reg_addr_t id_rs2,
    input  reg_addr_t ex_rs1,
    input  reg_addr_t ex_rs2,
    input  reg_addr_t mem_rd,
    input  reg_addr_t wb_rd,
    input  logic      mem_rf_we,
    input  logic      wb_rf_we,
    input  wb_sel_e   mem_wb_sel,
    output fwd_sel_e  fwd_a,
    output fwd_sel_e  fwd_b,
    output logic      byp_a,
    output logic      byp_b
);

    fwd_sel_e mem_kind;  // which memory-stage value holds the result

    // youngest producer wins, x0 never forwarded
    function automatic fwd_sel_e pick_src(input reg_addr_t src);
        if (src == '0) return fwd_reg;
        if (mem_rf_we && (mem_rd == src)) return mem_kind;
        if (wb_rf_we && (wb_rd == src)) return fwd_wb;
        return fwd_reg;
    endfunction

    always_comb begin
        case (mem_wb_sel)
            wb_mem:  mem_kind = fwd_mem_load;  // load data straight off the data port
            wb_pc4:  mem_kind = fwd_mem_pc4;
            default: mem_kind = fwd_mem_alu;
        endcase
        fwd_a = pick_src(ex_rs1);
        fwd_b = pick_src(ex_rs2);
    end

    // regfile write lands at the edge, decode reads the writeback value instead
    assign byp_a = wb_rf_we && (wb_rd != '0) && (wb_rd == id_rs1);
    assign byp_b = wb_rf_we && (wb_rd != '0) && (wb_rd == id_rs2);

endmodule

/* rtl/rv_decoder.sv */
// rv32i decoder: register fields, sign-extended immediates and control word
`timescale 1ns/1ps

module rv_decoder
    import rv_pkg::*;
(
    input  instr_t    instr,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output word_t     imm,
    output ctrl_t     ctrl
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // immediates, all sign extended from instr[31]
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0;     // anything not matched below stays a nop, rf_we low
        imm  = imm_u;  // u-type has no opcode here, harmless default
        case (opcode)
            opc_op: begin
                ctrl.rf_we = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = alu_add;
                    {7'b0100000, 3'b000}: ctrl.alu_op = alu_sub;
                    {7'b0000000, 3'b001}: ctrl.alu_op = alu_sll;
                    {7'b0000000, 3'b010}: ctrl.alu_op = alu_slt;
                    {7'b0000000, 3'b011}: ctrl.alu_op = alu_sltu;
                    {7'b0000000, 3'b100}: ctrl.alu_op = alu_xor;
                    {7'b0000000, 3'b101}: ctrl.alu_op = alu_srl;
                    {7'b0100000, 3'b101}: ctrl.alu_op = alu_sra;
                    {7'b0000000, 3'b110}: ctrl.alu_op = alu_or;
                    {7'b0000000, 3'b111}: ctrl.alu_op = alu_and;
                    default:              ctrl.rf_we  = 1'b0;  // mul group lands here
                endcase
            end
            opc_op_imm: begin
                imm          = imm_i;
                ctrl.use_imm = 1'b1;
                ctrl.rf_we   = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = alu_add;
                    3'b010: ctrl.alu_op = alu_slt;
                    3'b011: ctrl.alu_op = alu_sltu;
                    3'b100: ctrl.alu_op = alu_xor;
                    3'b110: ctrl.alu_op = alu_or;
                    3'b111: ctrl.alu_op = alu_and;
                    3'b001: begin
                        if (funct7 == 7'b0000000) ctrl.alu_op = alu_sll;
                        else                      ctrl.rf_we  = 1'b0;
                    end
                    default: begin  // 101, srli or srai
                        if (funct7 == 7'b0000000)      ctrl.alu_op = alu_srl;
                        else if (funct7 == 7'b0100000) ctrl.alu_op = alu_sra;
                        else                           ctrl.rf_we  = 1'b0;
                    end
                endcase
            end
            opc_load: begin
                imm          = imm_i;
                ctrl.use_imm = 1'b1;                 // address = rs1 + imm
                ctrl.wb_sel  = wb_mem;
                ctrl.rf_we   = (funct3 == 3'b010);   // lw only
            end
            opc_store: begin
                imm          = imm_s;
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = (funct3 == 3'b010);   // sw only
            end
            opc_branch: begin
                imm         = imm_b;
                ctrl.alu_op = alu_sub;               // flags come from a signed compare
                case (funct3)
                    3'b000:  ctrl.branch = br_eq;
                    3'b001:  ctrl.branch = br_ne;
                    3'b100:  ctrl.branch = br_lt;
                    3'b101:  ctrl.branch = br_ge;
                    default: ctrl.branch = br_none;
                endcase
            end
            opc_jal: begin
                imm         = imm_j;
                ctrl.jump   = 1'b1;
                ctrl.wb_sel = wb_pc4;                // link = pc+4
                ctrl.rf_we  = 1'b1;
            end
            opc_jalr: begin
                imm          = imm_i;
                ctrl.use_imm = 1'b1;
                ctrl.jump    = (funct3 == 3'b000);
                ctrl.jalr    = (funct3 == 3'b000);
                ctrl.wb_sel  = wb_pc4;
                ctrl.rf_we   = (funct3 == 3'b000);
            end
            opc_system: ctrl.halt = (instr == halt_instr);  // only ecall, others dropped
            default: ;
        endcase
    end

endmodule

/* rtl/rv_regfile.sv */
// rv32i register file: two async read ports, one write port, x0 hard wired to zero
`timescale 1ns/1ps

module rv_regfile
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      we,
    input  reg_addr_t rd_addr,
    input  word_t     rd_data
);

    word_t regs [1:nregs-1];  // no storage behind x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != '0)) begin  // writes to x0 dropped
            regs[rd_addr] <= rd_data;
        end
    end

    // same-cycle write is not seen here, decode bypass covers it
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* rtl/rv_alu.sv */
// rv32i alu: arithmetic, logic and shift ops, with equality and less-than flags
`timescale 1ns/1ps

module rv_alu
    import rv_pkg::*;
(
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    zero,
    output logic    less
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // upper bits of b ignored for shifts

    // flags for branches and set-less-than
    assign zero = (a == b);
    assign less = (op == alu_sltu) ? (a < b) : ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt);  // keep sign bit
            alu_slt,
            alu_sltu: result = word_t'(less);  // flag already picks signedness
            default:  result = a + b;
        endcase
    end

endmodule

/* rtl/rv_pkg.sv */
// rv32i package: widths, instruction constants, control enums, control word and stage structs
package rv_pkg;

    localparam int xlen  = 32;            // data and address width
    localparam int nregs = 32;            // architectural registers, x0 included

    localparam logic [xlen-1:0] nop_instr  = 32'h0000_0013;  // addi x0,x0,0
    localparam logic [xlen-1:0] halt_instr = 32'h0000_0073;  // ecall, used as halt marker

    typedef logic [xlen-1:0] word_t;      // data word or byte address
    typedef logic [31:0]     instr_t;     // raw instruction word
    typedef logic [4:0]      reg_addr_t;  // register index

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
    } alu_op_e;

    typedef enum logic [2:0] {br_none, br_eq, br_ne, br_lt, br_ge} branch_e;

    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_e;  // rd source

    // execute operand source, fwd_reg means take the id/ex register
    typedef enum logic [2:0] {fwd_reg, fwd_mem_alu, fwd_mem_load, fwd_mem_pc4, fwd_wb} fwd_sel_e;

    // ========================================================================
    // control word and pipeline stage registers
    // ========================================================================
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;  // alu operand b from imm
        branch_e branch;
        logic    jump;     // jal or jalr
        logic    jalr;     // target from alu result
        logic    mem_we;
        wb_sel_e wb_sel;
        logic    rf_we;
        logic    halt;
    } ctrl_t;

    typedef struct packed {
        instr_t instr;
        word_t  pc;
    } if_id_t;

    typedef struct packed {
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        ctrl_t     ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t     alu;         // result, also the data address
        word_t     store_data;  // forwarded rs2
        word_t     pc4;
        reg_addr_t rd;
        logic      mem_we;
        wb_sel_e   wb_sel;
        logic      rf_we;
        logic      halt;
    } ex_mem_t;

    typedef struct packed {
        word_t     alu;
        word_t     load_data;
        word_t     pc4;
        reg_addr_t rd;
        wb_sel_e   wb_sel;
        logic      rf_we;
        logic      halt;
    } mem_wb_t;

endpackage
